// ==== common/memory_game_macros.svh ====
`ifndef MEMORY_GAME_MACROS_SVH
`define MEMORY_GAME_MACROS_SVH

// Board layout
`define TILE_COUNT 16
`define PAIR_COUNT 8
`define GRID_COLS 4
`define TILE_W 80
`define TILE_H 60

// 640x480 timing in pixel ticks and lines
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

`define PIXEL_DIV 4
`define DEBOUNCE_LEN 7

// Tile keys, row by row
`define SC_1 9'h016
`define SC_2 9'h01E
`define SC_3 9'h026
`define SC_4 9'h025
`define SC_Q 9'h015
`define SC_W 9'h01D
`define SC_E 9'h024
`define SC_R 9'h02D
`define SC_A 9'h01C
`define SC_S 9'h01B
`define SC_D 9'h023
`define SC_F 9'h02B
`define SC_Z 9'h01A
`define SC_X 9'h022
`define SC_C 9'h021
`define SC_V 9'h02A

`define SC_SHIFT 9'h012
`define SC_ENTER 9'h05A

`endif

// ==== common/memory_game_pkg.sv ====
`include "memory_game_macros.svh"

package memory_game_pkg;

    typedef enum logic [1:0] {
        INIT,
        SHOW,
        GAME,
        FINISH
    } game_state_t;

    typedef logic [3:0] tile_idx_t;
    typedef logic [`TILE_COUNT-1:0] tile_mask_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

    typedef logic [8:0] scan_code_t;

    // One colour per image index, shared by tile i and tile i+8
    localparam rgb_t image_palette [`PAIR_COUNT] = '{
        12'hF00,
        12'h0F0,
        12'h00F,
        12'hFF0,
        12'hF0F,
        12'h0FF,
        12'hF80,
        12'hFFF
    };

endpackage

// ==== common/key_event_if.sv ====
interface key_event_if;
    import memory_game_pkg::*;

    logic press;
    logic tile_hit;
    tile_idx_t tile;
    logic shift_hit;
    logic enter_hit;

    modport mapper (
        output press,
        output tile_hit,
        output tile,
        output shift_hit,
        output enter_hit
    );

    modport control (
        input press,
        input tile_hit,
        input tile,
        input shift_hit,
        input enter_hit
    );

endinterface

// ==== common/vga_scan_if.sv ====
interface vga_scan_if;

    // One clk in every PIXEL_DIV
    logic tick;
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic active;

    modport source (
        output tick,
        output h_cnt,
        output v_cnt,
        output active
    );

    modport sink (
        input tick,
        input h_cnt,
        input v_cnt,
        input active
    );

endinterface

// ==== source/start_button.sv ====
`include "memory_game_macros.svh"

module start_button (
    input  logic clk,
    input  logic rst,
    input  logic button_i,
    output logic start_o
);

    logic [`DEBOUNCE_LEN-1:0] samples;
    logic all_high;
    logic all_high_q;

    assign all_high = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            all_high_q <= 1'b0;
            start_o <= 1'b0;
        end else begin
            samples <= {samples[`DEBOUNCE_LEN-2:0], button_i};
            all_high_q <= all_high;
            // Rising edge of the stable level only
            start_o <= all_high && !all_high_q;
        end
    end

endmodule

// ==== game/key_mapper.sv ====
`include "memory_game_macros.svh"

module key_mapper (
    input  logic                        key_valid_i,
    input  memory_game_pkg::scan_code_t key_code_i,
    key_event_if.mapper                 ev
);
    import memory_game_pkg::*;

    logic is_tile;
    tile_idx_t tile_num;

    always_comb begin
        is_tile = 1'b1;
        tile_num = '0;
        case (key_code_i)
            `SC_1: tile_num = 4'd0;
            `SC_2: tile_num = 4'd1;
            `SC_3: tile_num = 4'd2;
            `SC_4: tile_num = 4'd3;
            `SC_Q: tile_num = 4'd4;
            `SC_W: tile_num = 4'd5;
            `SC_E: tile_num = 4'd6;
            `SC_R: tile_num = 4'd7;
            `SC_A: tile_num = 4'd8;
            `SC_S: tile_num = 4'd9;
            `SC_D: tile_num = 4'd10;
            `SC_F: tile_num = 4'd11;
            `SC_Z: tile_num = 4'd12;
            `SC_X: tile_num = 4'd13;
            `SC_C: tile_num = 4'd14;
            `SC_V: tile_num = 4'd15;
            default: is_tile = 1'b0;
        endcase
    end

    // Unknown codes still give a press with no hit bit
    assign ev.press = key_valid_i;
    assign ev.tile_hit = key_valid_i && is_tile;
    assign ev.tile = tile_num;
    assign ev.shift_hit = key_valid_i && (key_code_i == `SC_SHIFT);
    assign ev.enter_hit = key_valid_i && (key_code_i == `SC_ENTER);

endmodule

// ==== game/game_control.sv ====
`include "memory_game_macros.svh"

module game_control (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_i,
    key_event_if.control                ev,
    output memory_game_pkg::game_state_t state_o,
    output memory_game_pkg::tile_mask_t  shown_o,
    output memory_game_pkg::tile_mask_t  matched_o,
    output memory_game_pkg::tile_mask_t  flip_o
);
    import memory_game_pkg::*;

    localparam int CNT_W = $clog2(`PAIR_COUNT + 1);

    game_state_t state;
    tile_mask_t shown;
    tile_mask_t matched;
    tile_mask_t flip;
    logic [CNT_W-1:0] pair_cnt;
    logic first_valid;
    tile_idx_t first_tile;
    logic shift_armed;
    logic pick;
    logic pair_hit;

    // Tile key that counts as a pick, not a flip
    assign pick = (state == GAME) && ev.press && ev.tile_hit && !shift_armed;

    // Same image, same orientation, two different unmatched tiles
    assign pair_hit = first_valid
        && (first_tile != ev.tile)
        && ((first_tile % `PAIR_COUNT) == (ev.tile % `PAIR_COUNT))
        && (flip[first_tile] == flip[ev.tile])
        && !matched[first_tile]
        && !matched[ev.tile];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INIT;
            shown <= '0;
            matched <= '0;
            flip <= '0;
            pair_cnt <= '0;
            first_valid <= 1'b0;
            shift_armed <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    shown <= '0;
                    matched <= '0;
                    flip <= '0;
                    pair_cnt <= '0;
                    first_valid <= 1'b0;
                    shift_armed <= 1'b0;
                    if (start_i) begin
                        shown <= '1;
                        state <= SHOW;
                    end
                end
                SHOW: begin
                    if (start_i) begin
                        shown <= '0;
                        state <= GAME;
                    end
                end
                GAME: begin
                    if (pair_cnt == CNT_W'(`PAIR_COUNT)) begin
                        shown <= '1;
                        matched <= '1;
                        state <= FINISH;
                    end else if (ev.press) begin
                        if (ev.enter_hit) begin
                            // Hide everything not yet paired
                            shown <= matched;
                            first_valid <= 1'b0;
                        end else if (ev.shift_hit) begin
                            shift_armed <= 1'b1;
                        end else if (ev.tile_hit) begin
                            if (shift_armed) begin
                                flip[ev.tile] <= ~flip[ev.tile];
                                shift_armed <= 1'b0;
                            end else begin
                                shown[ev.tile] <= 1'b1;
                                first_valid <= !first_valid;
                                if (pair_hit) begin
                                    matched[first_tile] <= 1'b1;
                                    matched[ev.tile] <= 1'b1;
                                    pair_cnt <= pair_cnt + 1'b1;
                                end
                            end
                        end
                    end
                end
                FINISH: begin
                    if (start_i) begin
                        state <= INIT;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pick && !first_valid) begin
            first_tile <= ev.tile;
        end
    end

    assign state_o = state;
    assign shown_o = shown;
    assign matched_o = matched;
    assign flip_o = flip;

endmodule

// ==== video/vga_timing.sv ====
`include "memory_game_macros.svh"

module vga_timing (
    input  logic clk,
    input  logic rst,
    vga_scan_if.source scan,
    output logic hsync_o,
    output logic vsync_o
);

    localparam int DIV_W = $clog2(`PIXEL_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic tick;
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic line_end;
    logic [9:0] v_next;

    assign tick = (div_cnt == DIV_W'(`PIXEL_DIV - 1));
    assign line_end = (h_cnt == 10'(`H_TOTAL - 1));
    assign v_next = (v_cnt == 10'(`V_TOTAL - 1)) ? 10'd0 : v_cnt + 10'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (tick) begin
            h_cnt <= line_end ? 10'd0 : h_cnt + 10'd1;
            if (line_end) begin
                v_cnt <= v_next;
            end
        end
    end

    // Sync registered one tick early so the low phase lines up with the counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else if (tick) begin
            hsync_o <= !((h_cnt >= 10'(`H_ACTIVE + `H_FRONT - 1))
                && (h_cnt < 10'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1)));
            if (line_end) begin
                vsync_o <= !((v_next >= 10'(`V_ACTIVE + `V_FRONT))
                    && (v_next < 10'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
            end
        end
    end

    assign scan.tick = tick;
    assign scan.h_cnt = h_cnt;
    assign scan.v_cnt = v_cnt;
    assign scan.active = (h_cnt < 10'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));

endmodule

// ==== video/tile_renderer.sv ====
`include "memory_game_macros.svh"

module tile_renderer (
    input  logic                       clk,
    input  logic                       rst,
    vga_scan_if.sink                   scan,
    input  memory_game_pkg::tile_mask_t shown_i,
    input  memory_game_pkg::tile_mask_t matched_i,
    input  memory_game_pkg::tile_mask_t flip_i,
    output memory_game_pkg::rgb_t      rgb_o
);
    import memory_game_pkg::*;

    logic [9:0] x;
    logic [9:0] y;
    logic [9:0] col;
    logic [9:0] band;
    logic [9:0] row;
    logic [9:0] row_mirror;
    tile_idx_t tile;
    logic visible;

    // Each image pixel is 2x2 screen pixels
    assign x = scan.h_cnt >> 1;
    assign y = scan.v_cnt >> 1;

    assign col = 10'(x / `TILE_W);
    assign band = 10'(y / `TILE_H);
    assign row = 10'(y % `TILE_H);
    assign tile = tile_idx_t'(band * `GRID_COLS + col);

    // Flip turns the tile upside down
    assign row_mirror = flip_i[tile] ? 10'(`TILE_H - 1) - row : row;

    assign visible = scan.active
        && (shown_i[tile] || matched_i[tile])
        && (row_mirror < 10'(`TILE_H / 2));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o <= '0;
        end else if (scan.tick) begin
            rgb_o <= visible ? image_palette[tile % `PAIR_COUNT] : 12'h000;
        end
    end

endmodule

// ==== source/memory_game_top.sv ====
module memory_game_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  logic                         key_valid_i,
    input  memory_game_pkg::scan_code_t  key_code_i,
    output logic [3:0]                   vga_red_o,
    output logic [3:0]                   vga_green_o,
    output logic [3:0]                   vga_blue_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output memory_game_pkg::game_state_t state_o,
    output memory_game_pkg::tile_mask_t  tile_shown_o,
    output memory_game_pkg::tile_mask_t  tile_matched_o
);
    import memory_game_pkg::*;

    logic start_pulse;
    tile_mask_t flip;
    rgb_t rgb;

    key_event_if key_ev ();
    vga_scan_if scan_bus ();

    start_button u_start_button (
        .clk      (clk),
        .rst      (rst),
        .button_i (start_i),
        .start_o  (start_pulse)
    );

    key_mapper u_key_mapper (
        .key_valid_i (key_valid_i),
        .key_code_i  (key_code_i),
        .ev          (key_ev.mapper)
    );

    game_control u_game_control (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start_pulse),
        .ev        (key_ev.control),
        .state_o   (state_o),
        .shown_o   (tile_shown_o),
        .matched_o (tile_matched_o),
        .flip_o    (flip)
    );

    vga_timing u_vga_timing (
        .clk     (clk),
        .rst     (rst),
        .scan    (scan_bus.source),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o)
    );

    tile_renderer u_tile_renderer (
        .clk       (clk),
        .rst       (rst),
        .scan      (scan_bus.sink),
        .shown_i   (tile_shown_o),
        .matched_i (tile_matched_o),
        .flip_i    (flip),
        .rgb_o     (rgb)
    );

    assign {vga_red_o, vga_green_o, vga_blue_o} = rgb;

endmodule

// ==== bench/memory_game_tb.sv ====
`include "memory_game_macros.svh"

module memory_game_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import memory_game_pkg::*;

    localparam int LINE_CLK = `H_TOTAL * `PIXEL_DIV;
    localparam int FRAME_CLK = `V_TOTAL * LINE_CLK;

    // Key or start press per row, then the status expected afterwards
    typedef struct packed {
        logic is_key;
        scan_code_t code;
        logic [1:0] state;
        tile_mask_t shown;
        tile_mask_t matched;
    } step_t;

    logic clk;
    logic rst;
    logic start;
    logic key_valid;
    scan_code_t key_code;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic hsync;
    logic vsync;
    game_state_t state;
    tile_mask_t shown;
    tile_mask_t matched;
    rgb_t rgb;
    step_t steps[$];
    scan_code_t tile_key[`TILE_COUNT];
    int value_errors;
    int timeouts;

    assign rgb = {red, green, blue};

    memory_game_top uut (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .key_valid_i    (key_valid),
        .key_code_i     (key_code),
        .vga_red_o      (red),
        .vga_green_o    (green),
        .vga_blue_o     (blue),
        .hsync_o        (hsync),
        .vsync_o        (vsync),
        .state_o        (state),
        .tile_shown_o   (shown),
        .tile_matched_o (matched)
    );

    always #10 clk = ~clk;

    task automatic expect_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic add_step(input logic is_key, input scan_code_t code, input logic [1:0] st,
            input tile_mask_t sh, input tile_mask_t ma);
        steps.push_back({is_key, code, st, sh, ma});
    endtask

    // Dark mode also expects both syncs high through the active area
    task automatic scan_frame(input bit dark);
        logic [`PAIR_COUNT-1:0] seen;
        bit bad;
        int hit;
        seen = '0;
        bad = 1'b0;
        for (int c = 1; c <= FRAME_CLK && !bad; c++) begin
            @(negedge clk);
            if (dark) begin
                assert (rgb == 12'h000 && (c >= `H_ACTIVE * `PIXEL_DIV || hsync)
                        && (c >= `V_ACTIVE * LINE_CLK || vsync)) else begin
                    value_errors++;
                    bad = 1'b1;
                    $display("error at %0t ns: rgb %h hsync %b vsync %b in dark frame",
                        $time, rgb, hsync, vsync);
                end
            end else if (rgb != 12'h000) begin
                hit = -1;
                for (int p = 0; p < `PAIR_COUNT; p++) begin
                    if (rgb == image_palette[p]) begin
                        hit = p;
                    end
                end
                assert (hit >= 0) else begin
                    value_errors++;
                    bad = 1'b1;
                    $display("error at %0t ns: rgb %h is not a palette colour", $time, rgb);
                end
                if (hit >= 0) begin
                    seen[hit] = 1'b1;
                end
            end
        end
        if (!dark) begin
            expect_value("palette colours seen", seen, {`PAIR_COUNT{1'b1}});
        end
    endtask

    task automatic wait_sync(input bit vertical, input logic level, output int cycles);
        cycles = 0;
        while ((vertical ? vsync : hsync) !== level && cycles < 2 * FRAME_CLK) begin
            @(negedge clk);
            cycles++;
        end
        if ((vertical ? vsync : hsync) !== level) begin
            timeouts++;
            $display("timeout: %s sync never went to %b", vertical ? "vertical" : "horizontal",
                level);
        end
    endtask

    initial begin
        step_t s;
        int low_clk;
        int high_clk;
        tile_mask_t exp_shown;
        tile_mask_t exp_matched;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        key_valid = 1'b0;
        key_code = '0;
        value_errors = 0;
        timeouts = 0;
        tile_key = '{`SC_1, `SC_2, `SC_3, `SC_4, `SC_Q, `SC_W, `SC_E, `SC_R,
                     `SC_A, `SC_S, `SC_D, `SC_F, `SC_Z, `SC_X, `SC_C, `SC_V};

        add_step(1'b0, '0, SHOW, '1, '0);
        add_step(1'b0, '0, GAME, '0, '0);
        // Tiles 0 and 8 pair up but 1 and 2 do not
        add_step(1'b1, tile_key[0], GAME, 16'h0001, 16'h0000);
        add_step(1'b1, tile_key[8], GAME, 16'h0101, 16'h0101);
        add_step(1'b1, tile_key[1], GAME, 16'h0103, 16'h0101);
        add_step(1'b1, tile_key[2], GAME, 16'h0107, 16'h0101);
        add_step(1'b1, `SC_ENTER, GAME, 16'h0101, 16'h0101);
        // Flipped tile 1 only pairs with 9 once 9 is flipped too
        add_step(1'b1, `SC_SHIFT, GAME, 16'h0101, 16'h0101);
        add_step(1'b1, tile_key[1], GAME, 16'h0101, 16'h0101);
        add_step(1'b1, tile_key[1], GAME, 16'h0103, 16'h0101);
        add_step(1'b1, tile_key[9], GAME, 16'h0303, 16'h0101);
        add_step(1'b1, `SC_SHIFT, GAME, 16'h0303, 16'h0101);
        add_step(1'b1, tile_key[9], GAME, 16'h0303, 16'h0101);
        add_step(1'b1, tile_key[1], GAME, 16'h0303, 16'h0101);
        add_step(1'b1, tile_key[9], GAME, 16'h0303, 16'h0303);
        exp_shown = 16'h0303;
        exp_matched = 16'h0303;
        for (int t = 2; t < `PAIR_COUNT; t++) begin
            exp_shown[t] = 1'b1;
            add_step(1'b1, tile_key[t], GAME, exp_shown, exp_matched);
            exp_shown[t + `PAIR_COUNT] = 1'b1;
            exp_matched[t] = 1'b1;
            exp_matched[t + `PAIR_COUNT] = 1'b1;
            add_step(1'b1, tile_key[t + `PAIR_COUNT], (t == `PAIR_COUNT - 1) ? FINISH : GAME,
                exp_shown, exp_matched);
        end
        add_step(1'b0, '0, INIT, '0, '0);

        repeat (2) @(negedge clk);
        rst = 1'b0;
        expect_value("state", state, INIT);
        expect_value("shown mask", shown, '0);
        expect_value("matched mask", matched, '0);
        expect_value("syncs", {hsync, vsync}, 2'b11);
        scan_frame(1'b1);

        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            if (s.is_key) begin
                key_valid = 1'b1;
                key_code = s.code;
                @(negedge clk);
                key_valid = 1'b0;
            end else begin
                start = 1'b1;
                repeat (10) @(negedge clk);
                start = 1'b0;
                repeat (10) @(negedge clk);
            end
            repeat (2) @(negedge clk);
            expect_value("state", state, s.state);
            expect_value("shown mask", shown, s.shown);
            expect_value("matched mask", matched, s.matched);
            if (s.state == SHOW) begin
                scan_frame(1'b0);
            end
        end

        // Sync widths in clk between falling edges
        wait_sync(1'b0, 1'b1, low_clk);
        wait_sync(1'b0, 1'b0, low_clk);
        wait_sync(1'b0, 1'b1, low_clk);
        wait_sync(1'b0, 1'b0, high_clk);
        expect_value("hsync low time", low_clk, `H_SYNC * `PIXEL_DIV);
        expect_value("hsync period", low_clk + high_clk, LINE_CLK);
        wait_sync(1'b1, 1'b1, low_clk);
        wait_sync(1'b1, 1'b0, low_clk);
        wait_sync(1'b1, 1'b1, low_clk);
        expect_value("vsync low time", low_clk, `V_SYNC * LINE_CLK);

        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+common
common/memory_game_pkg.sv
common/key_event_if.sv
common/vga_scan_if.sv
source/start_button.sv
game/key_mapper.sv
game/game_control.sv
video/vga_timing.sv
video/tile_renderer.sv
source/memory_game_top.sv
bench/memory_game_tb.sv

// ==== Bender.yml ====
package:
  name: memory_game

sources:
  - include_dirs:
      - common
    files:
      - common/memory_game_pkg.sv
      - common/key_event_if.sv
      - common/vga_scan_if.sv
      - source/start_button.sv
      - game/key_mapper.sv
      - game/game_control.sv
      - video/vga_timing.sv
      - video/tile_renderer.sv
      - source/memory_game_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/memory_game_tb.sv
